// File: common/rv_config.svh
// Core configuration for word width, data memory depth, reset PC and NOP encoding
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// Data and address width
`define RV_XLEN 32

// Data memory depth in words
`define RV_DMEM_WORDS 64

// First fetch address
`define RV_RESET_PC 32'h0000_0000

// ADDI x0,x0,0 for flushed slots
`define RV_NOP 32'h0000_0013

`endif

// File: common/rv_pkg.sv
// Shared RV32I pipeline types for ALU ops, branch ops and the instruction word views
package rv_pkg;

    // Major opcodes of the supported subset
    localparam logic [6:0] OP     = 7'b0110011;
    localparam logic [6:0] OP_IMM = 7'b0010011;
    localparam logic [6:0] LOAD   = 7'b0000011;
    localparam logic [6:0] STORE  = 7'b0100011;
    localparam logic [6:0] BRANCH = 7'b1100011;

    // ADD also covers ADDI and address generation, SUB covers branch compares
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_NE
    } branch_op_e;

    // Instruction formats ------------------
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    // Scrambled branch offset, bit 0 implied zero
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    // One word, four views
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
    } instr_u;

endpackage

// File: hw/rv_core/rv_fetch.sv
// Fetch stage holding the program counter and the IF/ID register
`timescale 1ns/1ns
`include "rv_config.svh"

module rv_fetch import rv_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                stall,
    input  logic                branch_taken,
    input  logic [`RV_XLEN-1:0] branch_target,
    output logic [`RV_XLEN-1:0] imem_addr,
    input  logic [`RV_XLEN-1:0] imem_instr,
    output logic                if_valid,
    output logic [`RV_XLEN-1:0] if_pc,
    output instr_u              if_instr
);

    logic [`RV_XLEN-1:0] pc;

    // Instruction memory answers in the same cycle
    assign imem_addr = pc;

    // PC update, branch beats stall
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RV_RESET_PC;
        end else if (branch_taken) begin
            pc <= branch_target;
        end else if (!stall) begin
            pc <= pc + `RV_XLEN'd4;
        end
    end

    // IF/ID register --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            if_valid <= 1'b0;
            if_pc    <= `RV_RESET_PC;
            if_instr <= `RV_NOP;
        end else if (branch_taken) begin
            // Younger slot squashed
            if_valid <= 1'b0;
            if_instr <= `RV_NOP;
        end else if (!stall) begin
            if_valid <= 1'b1;
            if_pc    <= pc;
            if_instr <= imem_instr;
        end
    end

endmodule

// File: hw/rv_core/rv_decode.sv
// Decode stage with immediate generation, load-use detection and the ID/EX register
`timescale 1ns/1ns
`include "rv_config.svh"

module rv_decode import rv_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                if_valid,
    input  logic [`RV_XLEN-1:0] if_pc,
    input  instr_u              if_instr,
    input  logic                branch_taken,
    input  logic                ex_mem_read,
    input  logic [4:0]          ex_rd,
    output logic [4:0]          rs1_addr,
    output logic [4:0]          rs2_addr,
    input  logic [`RV_XLEN-1:0] rs1_rdata,
    input  logic [`RV_XLEN-1:0] rs2_rdata,
    output logic                stall,
    output logic                id_valid,
    output logic [`RV_XLEN-1:0] id_pc,
    output alu_op_e             id_alu_op,
    output logic                id_alu_src_imm,
    output branch_op_e          id_branch_op,
    output logic                id_mem_read,
    output logic                id_mem_write,
    output logic                id_reg_write,
    output logic [4:0]          id_rs1,
    output logic [4:0]          id_rs2,
    output logic [4:0]          id_rd,
    output logic [`RV_XLEN-1:0] id_imm,
    output logic [`RV_XLEN-1:0] id_rs1_data,
    output logic [`RV_XLEN-1:0] id_rs2_data
);

    alu_op_e             alu_op;
    branch_op_e          branch_op;
    logic                alu_src_imm;
    logic                mem_read;
    logic                mem_write;
    logic                writes_rd;
    logic                uses_rs1;
    logic                uses_rs2;
    logic [`RV_XLEN-1:0] imm;

    // Register fields sit at the same bits in every format
    assign rs1_addr = if_instr.r.rs1;
    assign rs2_addr = if_instr.r.rs2;

    // Control decode --------------------
    always_comb begin
        alu_op      = ALU_ADD;
        branch_op   = BR_NONE;
        alu_src_imm = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        writes_rd   = 1'b0;
        uses_rs1    = 1'b0;
        uses_rs2    = 1'b0;
        imm         = '0;
        case (if_instr.r.opcode)
            OP: begin
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
                writes_rd = 1'b1;
                // funct7 bit 5 picks SUB and SRA
                case (if_instr.r.funct3)
                    3'b000:  alu_op = if_instr.r.funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b001:  alu_op = ALU_SLL;
                    3'b010:  alu_op = ALU_SLT;
                    3'b011:  alu_op = ALU_SLTU;
                    3'b100:  alu_op = ALU_XOR;
                    3'b101:  alu_op = if_instr.r.funct7[5] ? ALU_SRA : ALU_SRL;
                    3'b110:  alu_op = ALU_OR;
                    default: alu_op = ALU_AND;
                endcase
            end
            OP_IMM, LOAD: begin
                uses_rs1    = 1'b1;
                writes_rd   = 1'b1;
                alu_src_imm = 1'b1;
                mem_read    = (if_instr.i.opcode == LOAD);
                imm         = {{20{if_instr.i.imm[11]}}, if_instr.i.imm};
            end
            STORE: begin
                uses_rs1    = 1'b1;
                uses_rs2    = 1'b1;
                alu_src_imm = 1'b1;
                mem_write   = 1'b1;
                imm = {{20{if_instr.s.imm_hi[6]}}, if_instr.s.imm_hi, if_instr.s.imm_lo};
            end
            BRANCH: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                alu_op   = ALU_SUB;
                // BEQ is funct3 0, BNE is funct3 1
                if (if_instr.b.funct3 == 3'b000) begin
                    branch_op = BR_EQ;
                end else if (if_instr.b.funct3 == 3'b001) begin
                    branch_op = BR_NE;
                end
                imm = {{20{if_instr.b.imm12}}, if_instr.b.imm11, if_instr.b.imm10_5,
                       if_instr.b.imm4_1, 1'b0};
            end
            default: ;
        endcase
    end

    // Load in execute feeding a source of this instruction
    assign stall = if_valid && ex_mem_read && (ex_rd != 5'd0) &&
                   ((uses_rs1 && (rs1_addr == ex_rd)) || (uses_rs2 && (rs2_addr == ex_rd)));

    // ID/EX register --------------------
    always_ff @(posedge clk) begin
        if (rst || branch_taken || stall || !if_valid) begin
            // Bubble
            id_valid     <= 1'b0;
            id_mem_read  <= 1'b0;
            id_mem_write <= 1'b0;
            id_reg_write <= 1'b0;
            id_branch_op <= BR_NONE;
        end else begin
            id_valid     <= 1'b1;
            id_mem_read  <= mem_read;
            id_mem_write <= mem_write;
            // x0 writes retire without a write
            id_reg_write <= writes_rd && (if_instr.r.rd != 5'd0);
            id_branch_op <= branch_op;
        end
        // Payload
        id_pc          <= if_pc;
        id_alu_op      <= alu_op;
        id_alu_src_imm <= alu_src_imm;
        id_rs1         <= rs1_addr;
        id_rs2         <= rs2_addr;
        id_rd          <= if_instr.r.rd;
        id_imm         <= imm;
        id_rs1_data    <= rs1_rdata;
        id_rs2_data    <= rs2_rdata;
    end

endmodule

// File: hw/rv_core/rv_regfile.sv
// Integer register file with x0 tied to zero and write-through to the read ports
`timescale 1ns/1ns
`include "rv_config.svh"

module rv_regfile (
    input  logic                clk,
    input  logic                rst,
    input  logic [4:0]          rs1_addr,
    input  logic [4:0]          rs2_addr,
    output logic [`RV_XLEN-1:0] rs1_rdata,
    output logic [`RV_XLEN-1:0] rs2_rdata,
    input  logic                wb_valid,
    input  logic                wb_reg_write,
    input  logic [4:0]          wb_rd,
    input  logic [`RV_XLEN-1:0] wb_data
);

    logic [`RV_XLEN-1:0] regs [1:31];
    logic                we;

    assign we = wb_valid && wb_reg_write && (wb_rd != 5'd0);

    // Port 1, writeback in this cycle passes straight through
    always_comb begin
        if (rs1_addr == 5'd0) begin
            rs1_rdata = '0;
        end else if (we && (wb_rd == rs1_addr)) begin
            rs1_rdata = wb_data;
        end else begin
            rs1_rdata = regs[rs1_addr];
        end
    end

    // Port 2, same read path
    always_comb begin
        if (rs2_addr == 5'd0) begin
            rs2_rdata = '0;
        end else if (we && (wb_rd == rs2_addr)) begin
            rs2_rdata = wb_data;
        end else begin
            rs2_rdata = regs[rs2_addr];
        end
    end

    // Architectural state starts at zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wb_rd] <= wb_data;
        end
    end

endmodule

// File: hw/rv_core/rv_execute.sv
// Execute stage with operand forwarding, ALU, branch resolution and the EX/MEM register
`timescale 1ns/1ns
`include "rv_config.svh"

module rv_execute import rv_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                id_valid,
    input  logic [`RV_XLEN-1:0] id_pc,
    input  alu_op_e             id_alu_op,
    input  logic                id_alu_src_imm,
    input  branch_op_e          id_branch_op,
    input  logic                id_mem_read,
    input  logic                id_mem_write,
    input  logic                id_reg_write,
    input  logic [4:0]          id_rs1,
    input  logic [4:0]          id_rs2,
    input  logic [4:0]          id_rd,
    input  logic [`RV_XLEN-1:0] id_imm,
    input  logic [`RV_XLEN-1:0] id_rs1_data,
    input  logic [`RV_XLEN-1:0] id_rs2_data,
    input  logic                wb_valid,
    input  logic                wb_reg_write,
    input  logic [4:0]          wb_rd,
    input  logic [`RV_XLEN-1:0] wb_data,
    output logic                branch_taken,
    output logic [`RV_XLEN-1:0] branch_target,
    output logic                ex_valid,
    output logic [`RV_XLEN-1:0] ex_pc,
    output logic [`RV_XLEN-1:0] ex_alu_out,
    output logic [`RV_XLEN-1:0] ex_store_data,
    output logic [4:0]          ex_rd,
    output logic                ex_mem_read,
    output logic                ex_mem_write,
    output logic                ex_reg_write
);

    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;
    logic [`RV_XLEN-1:0] src_b;
    logic [`RV_XLEN-1:0] alu_out;
    logic                zero;

    // Youngest writer first
    // reg_write is never set for x0, so no rd check is needed
    // A load in EX/MEM cannot match here, the load-use stall removed it
    always_comb begin
        if (ex_valid && ex_reg_write && !ex_mem_read && (ex_rd == id_rs1)) begin
            op_a = ex_alu_out;
        end else if (wb_valid && wb_reg_write && (wb_rd == id_rs1)) begin
            op_a = wb_data;
        end else begin
            op_a = id_rs1_data;
        end
    end

    always_comb begin
        if (ex_valid && ex_reg_write && !ex_mem_read && (ex_rd == id_rs2)) begin
            op_b = ex_alu_out;
        end else if (wb_valid && wb_reg_write && (wb_rd == id_rs2)) begin
            op_b = wb_data;
        end else begin
            op_b = id_rs2_data;
        end
    end

    assign src_b = id_alu_src_imm ? id_imm : op_b;

    // ALU --------------------
    always_comb begin
        case (id_alu_op)
            ALU_SUB:  alu_out = op_a - src_b;
            ALU_SLL:  alu_out = op_a << src_b[4:0];
            ALU_SLT:  alu_out = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(src_b)};
            ALU_SLTU: alu_out = {{(`RV_XLEN-1){1'b0}}, op_a < src_b};
            ALU_XOR:  alu_out = op_a ^ src_b;
            ALU_SRL:  alu_out = op_a >> src_b[4:0];
            ALU_SRA:  alu_out = $signed(op_a) >>> src_b[4:0];
            ALU_OR:   alu_out = op_a | src_b;
            ALU_AND:  alu_out = op_a & src_b;
            default:  alu_out = op_a + src_b;
        endcase
    end

    // Branch compare rides on SUB
    assign zero          = (alu_out == '0);
    assign branch_taken  = id_valid && (((id_branch_op == BR_EQ) && zero) ||
                                        ((id_branch_op == BR_NE) && !zero));
    assign branch_target = id_pc + id_imm;

    // EX/MEM register --------------------
    always_ff @(posedge clk) begin
        if (rst || !id_valid) begin
            ex_valid     <= 1'b0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
            ex_reg_write <= 1'b0;
        end else begin
            ex_valid     <= 1'b1;
            ex_mem_read  <= id_mem_read;
            ex_mem_write <= id_mem_write;
            ex_reg_write <= id_reg_write;
        end
        ex_pc         <= id_pc;
        ex_alu_out    <= alu_out;
        ex_store_data <= op_b;
        ex_rd         <= id_rd;
    end

endmodule

// File: hw/rv_core/rv_mem_wb.sv
// Memory and writeback stages with the data memory, MEM/WB register and retire reports
`timescale 1ns/1ns
`include "rv_config.svh"

module rv_mem_wb (
    input  logic                clk,
    input  logic                rst,
    input  logic                ex_valid,
    input  logic [`RV_XLEN-1:0] ex_pc,
    input  logic [`RV_XLEN-1:0] ex_alu_out,
    input  logic [`RV_XLEN-1:0] ex_store_data,
    input  logic [4:0]          ex_rd,
    input  logic                ex_mem_read,
    input  logic                ex_mem_write,
    input  logic                ex_reg_write,
    output logic                wb_valid,
    output logic [4:0]          wb_rd,
    output logic                wb_reg_write,
    output logic [`RV_XLEN-1:0] wb_data,
    output logic                retire_valid,
    output logic [`RV_XLEN-1:0] retire_pc,
    output logic [4:0]          retire_rd,
    output logic                retire_we,
    output logic [`RV_XLEN-1:0] retire_data,
    output logic                store_valid,
    output logic [`RV_XLEN-1:0] store_addr,
    output logic [`RV_XLEN-1:0] store_data
);

    localparam int AW = $clog2(`RV_DMEM_WORDS);

    logic [`RV_XLEN-1:0] dmem [`RV_DMEM_WORDS];
    logic [AW-1:0]       idx;

    // Word index, byte offset dropped
    assign idx = ex_alu_out[AW+1:2];

    always_ff @(posedge clk) begin
        if (store_valid) begin
            dmem[idx] <= ex_store_data;
        end
    end

    // MEM/WB register, load data or ALU result
    always_ff @(posedge clk) begin
        if (rst || !ex_valid) begin
            wb_valid     <= 1'b0;
            wb_reg_write <= 1'b0;
        end else begin
            wb_valid     <= 1'b1;
            wb_reg_write <= ex_reg_write;
        end
        wb_rd     <= ex_rd;
        wb_data   <= ex_mem_read ? dmem[idx] : ex_alu_out;
        retire_pc <= ex_pc;
    end

    // Retire report shares MEM/WB
    assign retire_valid = wb_valid;
    assign retire_rd    = wb_rd;
    assign retire_we    = wb_reg_write;
    assign retire_data  = wb_data;

    // Store report while the store is in memory
    assign store_valid = ex_valid && ex_mem_write;
    assign store_addr  = ex_alu_out;
    assign store_data  = ex_store_data;

endmodule

// File: hw/rv_core/rv_core.sv
// Five-stage RV32I core top level wiring the pipeline stages and the register file
`timescale 1ns/1ns
`include "rv_config.svh"

module rv_core import rv_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    output logic [`RV_XLEN-1:0] imem_addr,
    input  logic [`RV_XLEN-1:0] imem_instr,
    output logic                retire_valid,
    output logic [`RV_XLEN-1:0] retire_pc,
    output logic [4:0]          retire_rd,
    output logic                retire_we,
    output logic [`RV_XLEN-1:0] retire_data,
    output logic                store_valid,
    output logic [`RV_XLEN-1:0] store_addr,
    output logic [`RV_XLEN-1:0] store_data
);

    // Hazard control --------------------
    logic                stall;
    logic                branch_taken;
    logic [`RV_XLEN-1:0] branch_target;

    // Fetch to decode
    logic                if_valid;
    logic [`RV_XLEN-1:0] if_pc;
    instr_u              if_instr;

    // Register file read
    logic [4:0]          rs1_addr;
    logic [4:0]          rs2_addr;
    logic [`RV_XLEN-1:0] rs1_rdata;
    logic [`RV_XLEN-1:0] rs2_rdata;

    // Decode to execute
    logic                id_valid;
    logic [`RV_XLEN-1:0] id_pc;
    alu_op_e             id_alu_op;
    logic                id_alu_src_imm;
    branch_op_e          id_branch_op;
    logic                id_mem_read;
    logic                id_mem_write;
    logic                id_reg_write;
    logic [4:0]          id_rs1;
    logic [4:0]          id_rs2;
    logic [4:0]          id_rd;
    logic [`RV_XLEN-1:0] id_imm;
    logic [`RV_XLEN-1:0] id_rs1_data;
    logic [`RV_XLEN-1:0] id_rs2_data;

    // Execute to memory
    logic                ex_valid;
    logic [`RV_XLEN-1:0] ex_pc;
    logic [`RV_XLEN-1:0] ex_alu_out;
    logic [`RV_XLEN-1:0] ex_store_data;
    logic [4:0]          ex_rd;
    logic                ex_mem_read;
    logic                ex_mem_write;
    logic                ex_reg_write;

    // Writeback and forwarding from MEM/WB
    logic                wb_valid;
    logic [4:0]          wb_rd;
    logic                wb_reg_write;
    logic [`RV_XLEN-1:0] wb_data;

    rv_fetch u_fetch (.*);

    // Load-use check looks at the ID/EX slot, the one in execute
    rv_decode u_decode (
        .ex_mem_read (id_mem_read),
        .ex_rd       (id_rd),
        .*
    );

    rv_regfile u_regfile (.*);

    rv_execute u_execute (.*);

    rv_mem_wb u_mem_wb (.*);

endmodule

// File: tb/rv_core_assert.sv
// Bound checks on reset quiet time, load-use stall length, fetch hold and branch pulses
`timescale 1ns/1ns
`include "rv_config.svh"

module rv_core_assert (
    input logic                clk,
    input logic                rst,
    input logic                stall,
    input logic                branch_taken,
    input logic [`RV_XLEN-1:0] imem_addr,
    input logic                retire_valid,
    input logic                store_valid
);

    // Read back by the testbench for its closing line
    int unsigned failures = 0;

    // Reset quiet time --------------------
    // Registers are cleared one edge after rst is first sampled
    quiet_after_reset: assert property (@(posedge clk)
        $past(rst) |-> !retire_valid && !store_valid)
        else begin
            $error("retire or store reported during reset or the cycle after it");
            failures++;
        end

    // Pipeline control --------------------
    // Load-use bubble is a single cycle
    single_stall: assert property (@(posedge clk) disable iff (rst)
        stall |=> !stall)
        else begin
            $error("stall held for two cycles in a row");
            failures++;
        end

    // Fetch holds its PC unless a branch redirects it
    hold_on_stall: assert property (@(posedge clk) disable iff (rst)
        (stall && !branch_taken) |=> $stable(imem_addr))
        else begin
            $error("imem_addr moved in a stalled cycle without a branch");
            failures++;
        end

    // Slot behind a taken branch is always a bubble
    single_branch: assert property (@(posedge clk) disable iff (rst)
        branch_taken |=> !branch_taken)
        else begin
            $error("branch_taken high for two cycles in a row");
            failures++;
        end

endmodule

bind rv_core rv_core_assert u_assert (.*);

// File: tb/tb_rv_core.sv
// Testbench for the five-stage core with a fixed program and a retire-order ISA model
`timescale 1ns/1ns
`include "rv_config.svh"

module tb_rv_core import rv_pkg::*; ();

    localparam int ROM_WORDS      = 64;
    localparam int TIMEOUT_CYCLES = 200;
    localparam int SEED           = 32'h33b2154f;

    logic        clk;
    logic        rst;
    logic [31:0] imem_addr;
    logic [31:0] imem_instr;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic [4:0]  retire_rd;
    logic        retire_we;
    logic [31:0] retire_data;
    logic        store_valid;
    logic [31:0] store_addr;
    logic [31:0] store_data;

    // Program ROM and ISA model state
    logic [31:0] rom [ROM_WORDS];
    int          prog_len;
    logic [31:0] xreg [32];
    logic [31:0] dmem_model [`RV_DMEM_WORDS];
    logic [31:0] model_pc;
    bit          program_done = 1'b0;
    bit          store_seen = 1'b0;
    int          retired = 0;
    int          cycles = 0;
    int          value_errors = 0;
    int          other_errors = 0;

    rv_core u_dut (.*);

    // Combinational ROM, whole address checked so nothing aliases past the end
    assign imem_instr = (imem_addr < ROM_WORDS * 4) ? rom[imem_addr[7:2]] : `RV_NOP;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
    end

    // Instruction encoders --------------------
    function automatic logic [31:0] alu_reg(input logic [6:0] f7, input logic [2:0] f3,
                                            input logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, OP};
    endfunction

    function automatic logic [31:0] addi(input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, OP_IMM};
    endfunction

    function automatic logic [31:0] lw(input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, LOAD};
    endfunction

    function automatic logic [31:0] sw(input logic [4:0] rs2, rs1, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE};
    endfunction

    // BEQ is funct3 0, BNE is funct3 1
    function automatic logic [31:0] cond_branch(input logic [2:0] f3, input logic [4:0] rs1,
                                                input logic [4:0] rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], BRANCH};
    endfunction

    function automatic logic [11:0] rand_imm();
        return 12'($urandom);
    endfunction

    function automatic logic [31:0] rom_word(input logic [31:0] addr);
        return (addr < ROM_WORDS * 4) ? rom[addr[7:2]] : `RV_NOP;
    endfunction

    task automatic emit(input logic [31:0] word);
        rom[prog_len] = word;
        prog_len++;
    endtask

    // Program --------------------
    task automatic load_program();
        logic [11:0] off_a;
        logic [11:0] off_b;
        off_a = 12'(($urandom % 8) * 4);
        off_b = off_a + 12'd32;
        prog_len = 0;
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = `RV_NOP;
        end
        // ALU chain, forwarding at distances one to three
        emit(addi(5'd1, 5'd0, rand_imm()));
        emit(addi(5'd2, 5'd1, rand_imm()));
        emit(alu_reg(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
        emit(alu_reg(7'h20, 3'b000, 5'd4, 5'd3, 5'd1));
        emit(alu_reg(7'h00, 3'b001, 5'd5, 5'd4, 5'd2));
        emit(alu_reg(7'h00, 3'b010, 5'd6, 5'd5, 5'd3));
        emit(alu_reg(7'h00, 3'b011, 5'd7, 5'd5, 5'd3));
        emit(alu_reg(7'h00, 3'b100, 5'd8, 5'd7, 5'd4));
        emit(alu_reg(7'h00, 3'b101, 5'd9, 5'd4, 5'd2));
        emit(alu_reg(7'h20, 3'b101, 5'd11, 5'd4, 5'd2));
        emit(alu_reg(7'h00, 3'b110, 5'd12, 5'd9, 5'd11));
        emit(alu_reg(7'h00, 3'b111, 5'd13, 5'd12, 5'd3));
        // x0 write, then x0 read
        emit(addi(5'd0, 5'd13, rand_imm()));
        emit(alu_reg(7'h00, 3'b000, 5'd14, 5'd0, 5'd13));
        // Stores, loads and load-use stalls
        emit(addi(5'd10, 5'd0, 12'd64));
        emit(sw(5'd3, 5'd10, off_a));
        emit(sw(5'd4, 5'd10, off_b));
        emit(lw(5'd15, 5'd10, off_a));
        emit(alu_reg(7'h00, 3'b000, 5'd16, 5'd15, 5'd1));
        emit(lw(5'd17, 5'd10, off_b));
        emit(sw(5'd17, 5'd10, 12'd96));
        emit(lw(5'd18, 5'd10, 12'd96));
        emit(alu_reg(7'h20, 3'b000, 5'd19, 5'd18, 5'd16));
        // Taken BEQ skips two
        emit(cond_branch(3'b000, 5'd3, 5'd3, 13'd12));
        emit(addi(5'd20, 5'd0, 12'd1));
        emit(addi(5'd21, 5'd0, 12'd2));
        emit(cond_branch(3'b001, 5'd3, 5'd3, 13'd12));
        emit(addi(5'd22, 5'd6, rand_imm()));
        emit(addi(5'd23, 5'd0, 12'd5));
        // Taken BNE on a just-written operand
        emit(cond_branch(3'b001, 5'd23, 5'd0, 13'd12));
        emit(addi(5'd24, 5'd0, 12'd3));
        emit(alu_reg(7'h00, 3'b000, 5'd25, 5'd23, 5'd23));
        emit(cond_branch(3'b000, 5'd23, 5'd0, 13'd8));
        emit(addi(5'd26, 5'd23, rand_imm()));
        emit(alu_reg(7'h00, 3'b000, 5'd27, 5'd26, 5'd16));
        // Load feeding a taken branch
        emit(lw(5'd28, 5'd10, off_a));
        emit(cond_branch(3'b000, 5'd28, 5'd3, 13'd8));
        emit(addi(5'd29, 5'd0, 12'd7));
        emit(alu_reg(7'h00, 3'b111, 5'd30, 5'd28, 5'd27));
        emit(alu_reg(7'h00, 3'b110, 5'd31, 5'd30, 5'd5));
        emit(alu_reg(7'h00, 3'b000, 5'd1, 5'd31, 5'd22));
        emit(alu_reg(7'h00, 3'b100, 5'd0, 5'd1, 5'd2));
        emit(alu_reg(7'h00, 3'b000, 5'd2, 5'd0, 5'd1));
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
        value_errors++;
    endtask

    // ISA model --------------------
    // Steps one instruction per retirement and checks it
    task automatic check_retire();
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] result;
        logic [31:0] next_pc;
        logic        we;
        ins     = rom_word(model_pc);
        a       = xreg[ins[19:15]];
        b       = xreg[ins[24:20]];
        imm_i   = {{20{ins[31]}}, ins[31:20]};
        imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b   = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        result  = '0;
        we      = 1'b0;
        next_pc = model_pc + 32'd4;
        case (ins[6:0])
            OP: begin
                we = 1'b1;
                case (ins[14:12])
                    3'b000:  result = ins[30] ? a - b : a + b;
                    3'b001:  result = a << b[4:0];
                    3'b010:  result = {31'd0, $signed(a) < $signed(b)};
                    3'b011:  result = {31'd0, a < b};
                    3'b100:  result = a ^ b;
                    3'b101:  result = ins[30] ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
                    3'b110:  result = a | b;
                    default: result = a & b;
                endcase
            end
            OP_IMM: begin
                we     = 1'b1;
                result = a + imm_i;
            end
            LOAD: begin
                we     = 1'b1;
                result = dmem_model[6'((a + imm_i) >> 2)];
            end
            STORE: begin
                // Every store shows up on the store port before it retires
                assert (store_seen) else begin
                    $display("Error at %0t: store at pc %h retired without a store report",
                             $time, model_pc);
                    other_errors++;
                end
                store_seen = 1'b0;
                dmem_model[6'((a + imm_s) >> 2)] = b;
            end
            BRANCH: begin
                if (((ins[14:12] == 3'b000) && (a == b)) ||
                    ((ins[14:12] == 3'b001) && (a != b))) begin
                    next_pc = model_pc + imm_b;
                end
            end
            default: ;
        endcase
        // x0 never takes a write
        we = we && (ins[11:7] != 5'd0);
        assert (retire_pc === model_pc) else report_mismatch("retire_pc", model_pc, retire_pc);
        assert (retire_we === we) else report_mismatch("retire_we", 32'(we), 32'(retire_we));
        if (we) begin
            assert (retire_rd === ins[11:7])
                else report_mismatch("retire_rd", 32'(ins[11:7]), 32'(retire_rd));
            assert (retire_data === result)
                else report_mismatch("retire_data", result, retire_data);
            xreg[ins[11:7]] = result;
        end
        model_pc = next_pc;
        retired++;
        if (model_pc == prog_len * 4) begin
            program_done = 1'b1;
        end
    endtask

    // Store in memory stage is the next instruction to retire
    task automatic check_store();
        logic [31:0] ins;
        logic [31:0] addr;
        ins = rom_word(model_pc);
        assert (ins[6:0] == STORE) else begin
            $display("Error at %0t: store reported while pc %h holds no store", $time, model_pc);
            other_errors++;
        end
        if (ins[6:0] == STORE) begin
            store_seen = 1'b1;
            addr = xreg[ins[19:15]] + {{20{ins[31]}}, ins[31:25], ins[11:7]};
            assert (store_addr === addr) else report_mismatch("store_addr", addr, store_addr);
            assert (store_data === xreg[ins[24:20]])
                else report_mismatch("store_data", xreg[ins[24:20]], store_data);
        end
    endtask

    // Outputs are registered, so the falling edge sees them settled
    always @(negedge clk) begin
        if (!rst) begin
            if (retire_valid === 1'b1) begin
                check_retire();
            end
            if (store_valid === 1'b1) begin
                check_store();
            end
        end
    end

    initial begin : main
        int unsigned assert_fails;
        rst = 1'b1;
        void'($urandom(SEED));
        load_program();
        for (int i = 0; i < 32; i++) begin
            xreg[i] = '0;
        end
        for (int i = 0; i < `RV_DMEM_WORDS; i++) begin
            dmem_model[i] = '0;
        end
        model_pc = `RV_RESET_PC;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        while (!program_done && (cycles < TIMEOUT_CYCLES)) begin
            @(posedge clk);
        end
        if (program_done) begin
            // Let the bound checks see the tail
            repeat (3) @(posedge clk);
        end else begin
            $display("Timeout: the program did not finish within %0d cycles", TIMEOUT_CYCLES);
            other_errors++;
        end
        @(negedge clk);
        assert_fails = u_dut.u_assert.failures;
        $display("Retired %0d, value errors %0d, other errors %0d, assertion failures %0d",
                 retired, value_errors, other_errors, assert_fails);
        if ((value_errors + other_errors + assert_fails) == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+common
common/rv_pkg.sv
hw/rv_core/rv_fetch.sv
hw/rv_core/rv_decode.sv
hw/rv_core/rv_regfile.sv
hw/rv_core/rv_execute.sv
hw/rv_core/rv_mem_wb.sv
hw/rv_core/rv_core.sv
tb/rv_core_assert.sv
tb/tb_rv_core.sv

// File: Bender.yml
package:
  name: rv_core

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/rv_pkg.sv
      - hw/rv_core/rv_fetch.sv
      - hw/rv_core/rv_decode.sv
      - hw/rv_core/rv_regfile.sv
      - hw/rv_core/rv_execute.sv
      - hw/rv_core/rv_mem_wb.sv
      - hw/rv_core/rv_core.sv
  - target: test
    include_dirs:
      - common
    files:
      - tb/rv_core_assert.sv
      - tb/tb_rv_core.sv
